//--- project.f
verilog/mci_reg_pkg.sv
verilog/mci_ctrl_pkg.sv
verilog/mci_boot_seqr.sv
verilog/mci_wdt.sv
verilog/mci_reg_bank.sv
verilog/mci_top.sv
sim/mci_top_asserts.sv
sim/mci_top_tb.sv

//--- Makefile
TOP := mci_top_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- sim/mci_top_tb.sv
`timescale 1ns/100ps

module mci_top_tb;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                        clk;
    logic                        rst_n_i;
    mci_reg_pkg::mci_reg_req_t   reg_req_i;
    mci_reg_pkg::reg_data_t      reg_rdata_o;
    logic                        lc_done_i;
    logic                        fc_opt_done_i;
    logic                        mci_boot_seq_brkpoint_i;
    logic                        lc_init_o;
    logic                        fc_opt_init_o;
    logic                        mcu_rst_b_o;
    logic                        cptra_rst_b_o;
    mci_reg_pkg::agg_error_t     agg_error_fatal_i;
    mci_reg_pkg::agg_error_t     agg_error_non_fatal_i;
    logic                        all_error_fatal_o;
    logic                        all_error_non_fatal_o;
    logic                        mci_intr_o;
    logic                        nmi_intr_o;
    mci_reg_pkg::generic_wires_t mci_generic_input_wires_i;
    mci_reg_pkg::generic_wires_t mci_generic_output_wires_o;

    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int cycles = 0;

    mci_top mci_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run limit that ends any hung wait
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // All tasks start and end 1 ns after a rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic reg_write(input mci_reg_pkg::reg_addr_t addr,
                             input mci_reg_pkg::reg_data_t data);
        reg_req_i = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        step(1);
        reg_req_i = '0;
    endtask

    task automatic reg_read(input mci_reg_pkg::reg_addr_t addr,
                            input mci_reg_pkg::reg_data_t exp, input string name);
        reg_req_i = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
        step(1);
        reg_req_i = '0;
        check_value(name, 64'(reg_rdata_o), 64'(exp));
    endtask

    task automatic test_done(input string name);
        tests++;
        $display("Test %s finished, %0d errors so far", name, errors);
    endtask

    task automatic error_path(input bit fatal);
        mci_reg_pkg::reg_addr_t stat_addr;
        mci_reg_pkg::reg_addr_t mask_addr;
        mci_reg_pkg::agg_error_t bit_v;
        string out_name;
        stat_addr = fatal ? mci_reg_pkg::ADDR_ERROR_FATAL : mci_reg_pkg::ADDR_ERROR_NON_FATAL;
        mask_addr = fatal ? mci_reg_pkg::ADDR_ERROR_FATAL_MASK
                          : mci_reg_pkg::ADDR_ERROR_NON_FATAL_MASK;
        out_name = fatal ? "all_error_fatal_o" : "all_error_non_fatal_o";
        bit_v = 32'h1 << $urandom_range(0, 31);
        for (int masked = 0; masked < 2; masked++) begin
            reg_write(mask_addr, masked ? bit_v : 32'h0);
            if (fatal) agg_error_fatal_i = bit_v;
            else agg_error_non_fatal_i = bit_v;
            step(1);
            agg_error_fatal_i     = '0;
            agg_error_non_fatal_i = '0;
            check_value(out_name, 64'(fatal ? all_error_fatal_o : all_error_non_fatal_o),
                        64'(masked == 0));
            step(3);
            check_value(out_name, 64'(fatal ? all_error_fatal_o : all_error_non_fatal_o),
                        64'(masked == 0));
            reg_read(stat_addr, bit_v, "error_status");
            reg_write(stat_addr, bit_v);
            check_value(out_name, 64'(fatal ? all_error_fatal_o : all_error_non_fatal_o),
                        64'h0);
        end
        reg_write(mask_addr, 32'h0);
    endtask

    // Cascade run from the T1 enable to the NMI or to the T1 service
    task automatic wdt_run(input int p1, input int p2, input bit service);
        int n;
        reg_write(mci_reg_pkg::ADDR_WDT_T1_EN, 32'h1);
        n = 0;
        while (!mci_intr_o) begin
            step(1);
            n++;
        end
        check_value("mci_intr_o delay", 64'(n), 64'(p1 + 3));
        if (service) begin
            reg_write(mci_reg_pkg::ADDR_WDT_STATUS, 32'h1);
            reg_write(mci_reg_pkg::ADDR_WDT_T1_EN, 32'h0);
            step(p2 + 6);
            check_value("nmi_intr_o", 64'(nmi_intr_o), 64'h0);
        end else begin
            n = 0;
            while (!nmi_intr_o) begin
                step(1);
                n++;
            end
            check_value("nmi_intr_o delay", 64'(n), 64'(p2 + 2));
            check_value("all_error_fatal_o", 64'(all_error_fatal_o), 64'h1);
            reg_write(mci_reg_pkg::ADDR_WDT_T1_EN, 32'h0);
            reg_write(mci_reg_pkg::ADDR_WDT_STATUS, 32'h3);
        end
    endtask

    initial begin
        int p1;
        int p2;
        mci_reg_pkg::reg_data_t  wd [4];
        mci_reg_pkg::reg_addr_t  pa [4];
        void'($urandom(32'h53d9));
        rst_n_i = 1'b0;
        reg_req_i = '0;
        lc_done_i = 1'b0;
        fc_opt_done_i = 1'b0;
        mci_boot_seq_brkpoint_i = 1'b1;
        agg_error_fatal_i = '0;
        agg_error_non_fatal_i = '0;
        mci_generic_input_wires_i = '0;
        step(2);
        rst_n_i = 1'b1;

        // LCC and fuse controller answer after random delays
        while (!lc_init_o) step(1);
        step($urandom_range(1, 5));
        lc_done_i = 1'b1;
        while (lc_init_o) step(1);
        lc_done_i = 1'b0;
        while (!fc_opt_init_o) step(1);
        step($urandom_range(1, 5));
        fc_opt_done_i = 1'b1;
        while (fc_opt_init_o) step(1);
        fc_opt_done_i = 1'b0;
        test_done("boot_order");

        step(6);
        check_value("mcu_rst_b_o", 64'(mcu_rst_b_o), 64'h0);
        reg_write(mci_reg_pkg::ADDR_BOOT_GO, 32'h1);
        while (!cptra_rst_b_o) step(1);
        check_value("mcu_rst_b_o", 64'(mcu_rst_b_o), 64'h1);
        test_done("brkpoint_go");

        reg_write(mci_reg_pkg::ADDR_RESET_REQUEST, 32'h1);
        while (mcu_rst_b_o) step(1);
        while (!mcu_rst_b_o) step(1);
        // State BOOT_RUN in bits 3:1, mcu_reset_once in bit 0
        reg_read(mci_reg_pkg::ADDR_BOOT_STATUS, {28'h0, 3'd4, 1'b1}, "boot_status");
        test_done("mcu_reset");

        error_path(1'b1);
        error_path(1'b0);
        test_done("error_aggregation");

        p1 = $urandom_range(4, 11);
        p2 = $urandom_range(4, 11);
        reg_write(mci_reg_pkg::ADDR_WDT_T1_PERIOD0, p1);
        reg_write(mci_reg_pkg::ADDR_WDT_T1_PERIOD1, 32'h0);
        reg_write(mci_reg_pkg::ADDR_WDT_T2_PERIOD0, p2);
        reg_write(mci_reg_pkg::ADDR_WDT_T2_PERIOD1, 32'h0);
        reg_write(mci_reg_pkg::ADDR_WDT_T2_EN, 32'h0);
        wdt_run(p1, p2, 1'b0);
        wdt_run(p1, p2, 1'b1);
        test_done("watchdog_cascade");

        pa = '{mci_reg_pkg::ADDR_WDT_T1_PERIOD0, mci_reg_pkg::ADDR_WDT_T1_PERIOD1,
               mci_reg_pkg::ADDR_WDT_T2_PERIOD0, mci_reg_pkg::ADDR_WDT_T2_PERIOD1};
        foreach (pa[i]) begin
            wd[i] = $urandom;
            reg_write(pa[i], wd[i]);
            reg_read(pa[i], wd[i], "wdt_period");
        end
        mci_generic_input_wires_i = {$urandom, $urandom};
        reg_read(mci_reg_pkg::ADDR_GENERIC_IN0, mci_generic_input_wires_i[31:0], "generic_in0");
        reg_read(mci_reg_pkg::ADDR_GENERIC_IN1, mci_generic_input_wires_i[63:32], "generic_in1");
        wd[0] = $urandom;
        wd[1] = $urandom;
        reg_write(mci_reg_pkg::ADDR_GENERIC_OUT0, wd[0]);
        reg_write(mci_reg_pkg::ADDR_GENERIC_OUT1, wd[1]);
        check_value("mci_generic_output_wires_o", mci_generic_output_wires_o, {wd[1], wd[0]});
        reg_read(12'hFF0, 32'h0, "unmapped");
        test_done("register_readback");

        errors += mci_top_i.mci_top_asserts_i.fail_count;
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- sim/mci_top_asserts.sv
`timescale 1ns/100ps

module mci_top_asserts (
    input logic                        clk,
    input logic                        rst_n_i,
    input mci_reg_pkg::mci_reg_req_t   reg_req_i,
    input logic                        fc_opt_done_i,
    input logic                        mci_boot_seq_brkpoint_i,
    input logic                        lc_init_o,
    input logic                        fc_opt_init_o,
    input logic                        mcu_rst_b_o,
    input logic                        cptra_rst_b_o,
    input mci_reg_pkg::agg_error_t     agg_error_fatal_i,
    input mci_reg_pkg::agg_error_t     agg_error_non_fatal_i,
    input logic                        all_error_fatal_o,
    input logic                        all_error_non_fatal_o,
    input logic                        mci_intr_o,
    input logic                        nmi_intr_o
);

    int   fail_count = 0;
    logic fc_seen_q;
    logic go_seen_q;
    logic go_wr;

    assign go_wr = reg_req_i.wr && reg_req_i.wdata[0] &&
                   reg_req_i.addr == mci_reg_pkg::ADDR_BOOT_GO;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            fc_seen_q <= 1'b0;
            go_seen_q <= 1'b0;
        end else begin
            fc_seen_q <= fc_seen_q | fc_opt_done_i;
            go_seen_q <= go_seen_q | go_wr;
        end
    end

    // Boot order
    init_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(lc_init_o && fc_opt_init_o))
        else begin
            fail_count++;
            $error("lc_init_o and fc_opt_init_o high together");
        end
    mcu_release_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(mcu_rst_b_o) |-> !lc_init_o && !fc_opt_init_o && fc_seen_q &&
                               (!mci_boot_seq_brkpoint_i || go_seen_q))
        else begin
            fail_count++;
            $error("mcu_rst_b_o released out of order");
        end

    // Caliptra release two cycles after BOOT_GO and no later fall
    cptra_after_go: assert property (@(posedge clk) disable iff (!rst_n_i)
        go_wr && fc_seen_q && !cptra_rst_b_o && (mcu_rst_b_o || mci_boot_seq_brkpoint_i)
        |-> ##3 $rose(cptra_rst_b_o))
        else begin
            fail_count++;
            $error("cptra_rst_b_o did not rise two cycles after BOOT_GO");
        end
    cptra_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$fell(cptra_rst_b_o))
        else begin
            fail_count++;
            $error("cptra_rst_b_o fell");
        end

    // MCU reset hold of 16 cycles
    mcu_rst_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(mcu_rst_b_o) |-> (!mcu_rst_b_o) [*16] ##1 mcu_rst_b_o)
        else begin
            fail_count++;
            $error("mcu_rst_b_o low time is not 16 cycles");
        end

    // Watchdog cascade
    nmi_cascade: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(nmi_intr_o) |-> mci_intr_o)
        else begin
            fail_count++;
            $error("nmi_intr_o rose without mci_intr_o");
        end

    // Error outputs rise only on an event and fall only on a register write
    fatal_rise: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(all_error_fatal_o) |-> $past(|agg_error_fatal_i) || nmi_intr_o)
        else begin
            fail_count++;
            $error("all_error_fatal_o rose without an error");
        end
    fatal_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(all_error_fatal_o) |-> $past(reg_req_i.wr))
        else begin
            fail_count++;
            $error("all_error_fatal_o fell without a write");
        end
    non_fatal_rise: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(all_error_non_fatal_o) |-> $past(|agg_error_non_fatal_i))
        else begin
            fail_count++;
            $error("all_error_non_fatal_o rose without an error");
        end
    non_fatal_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(all_error_non_fatal_o) |-> $past(reg_req_i.wr))
        else begin
            fail_count++;
            $error("all_error_non_fatal_o fell without a write");
        end

endmodule

bind mci_top mci_top_asserts mci_top_asserts_i (.*);

//--- verilog/mci_top.sv
`timescale 1ns/100ps

module mci_top (
    input  logic                        clk,
    input  logic                        rst_n_i,
    // Register port
    input  mci_reg_pkg::mci_reg_req_t   reg_req_i,
    output mci_reg_pkg::reg_data_t      reg_rdata_o,
    // LCC and fuse controller handshakes
    input  logic                        lc_done_i,
    input  logic                        fc_opt_done_i,
    input  logic                        mci_boot_seq_brkpoint_i,
    output logic                        lc_init_o,
    output logic                        fc_opt_init_o,
    // Reset controls
    output logic                        mcu_rst_b_o,
    output logic                        cptra_rst_b_o,
    // Subsystem errors
    input  mci_reg_pkg::agg_error_t     agg_error_fatal_i,
    input  mci_reg_pkg::agg_error_t     agg_error_non_fatal_i,
    output logic                        all_error_fatal_o,
    output logic                        all_error_non_fatal_o,
    // MCU interrupts
    output logic                        mci_intr_o,
    output logic                        nmi_intr_o,
    // Generic in/out
    input  mci_reg_pkg::generic_wires_t mci_generic_input_wires_i,
    output mci_reg_pkg::generic_wires_t mci_generic_output_wires_o
);

    mci_ctrl_pkg::boot_ctrl_t   boot_ctrl;
    mci_ctrl_pkg::boot_status_t boot_status;
    mci_ctrl_pkg::wdt_cfg_t     wdt_cfg;
    mci_ctrl_pkg::wdt_status_t  wdt_status;
    logic                       t1_serviced;
    logic                       t2_serviced;

    mci_reg_bank i_mci_reg_bank (
        .clk,
        .rst_n_i,
        .reg_req_i,
        .reg_rdata_o,
        .boot_ctrl_o   (boot_ctrl),
        .boot_status_i (boot_status),
        .wdt_cfg_o     (wdt_cfg),
        .wdt_status_i  (wdt_status),
        .t1_serviced_o (t1_serviced),
        .t2_serviced_o (t2_serviced),
        .agg_error_fatal_i,
        .agg_error_non_fatal_i,
        .mci_generic_input_wires_i,
        .mci_generic_output_wires_o,
        .all_error_fatal_o,
        .all_error_non_fatal_o,
        .mci_intr_o,
        .nmi_intr_o
    );

    mci_boot_seqr i_mci_boot_seqr (
        .clk,
        .rst_n_i,
        .boot_ctrl_i   (boot_ctrl),
        .lc_done_i,
        .fc_opt_done_i,
        .mci_boot_seq_brkpoint_i,
        .lc_init_o,
        .fc_opt_init_o,
        .mcu_rst_b_o,
        .cptra_rst_b_o,
        .boot_status_o (boot_status)
    );

    mci_wdt i_mci_wdt (
        .clk,
        .rst_n_i,
        .wdt_cfg_i     (wdt_cfg),
        .t1_serviced_i (t1_serviced),
        .t2_serviced_i (t2_serviced),
        .wdt_status_o  (wdt_status)
    );

endmodule

//--- verilog/mci_reg_bank.sv
`timescale 1ns/100ps

module mci_reg_bank (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  mci_reg_pkg::mci_reg_req_t   reg_req_i,
    output mci_reg_pkg::reg_data_t      reg_rdata_o,
    output mci_ctrl_pkg::boot_ctrl_t    boot_ctrl_o,
    input  mci_ctrl_pkg::boot_status_t  boot_status_i,
    output mci_ctrl_pkg::wdt_cfg_t      wdt_cfg_o,
    input  mci_ctrl_pkg::wdt_status_t   wdt_status_i,
    output logic                        t1_serviced_o,
    output logic                        t2_serviced_o,
    input  mci_reg_pkg::agg_error_t     agg_error_fatal_i,
    input  mci_reg_pkg::agg_error_t     agg_error_non_fatal_i,
    input  mci_reg_pkg::generic_wires_t mci_generic_input_wires_i,
    output mci_reg_pkg::generic_wires_t mci_generic_output_wires_o,
    output logic                        all_error_fatal_o,
    output logic                        all_error_non_fatal_o,
    output logic                        mci_intr_o,
    output logic                        nmi_intr_o
);

    logic                        boot_go_q;
    logic                        mcu_rst_req_q;
    logic [1:0]                  wdt_en_q;
    logic [1:0]                  wdt_restart_q;
    logic [1:0]                  wdt_stat_q;
    logic [1:0]                  wdt_stat_set;
    logic [1:0]                  wdt_stat_clr;
    mci_reg_pkg::agg_error_t     err_fatal_q;
    mci_reg_pkg::agg_error_t     err_non_fatal_q;
    mci_reg_pkg::agg_error_t     fatal_mask_q;
    mci_reg_pkg::agg_error_t     non_fatal_mask_q;
    mci_reg_pkg::agg_error_t     fatal_clr;
    mci_reg_pkg::agg_error_t     non_fatal_clr;
    mci_reg_pkg::generic_wires_t gen_out_q;
    mci_reg_pkg::reg_data_t      rdata;
    mci_reg_pkg::reg_data_t [mci_ctrl_pkg::WDT_PERIOD_DWORDS-1:0] t1_period_q;
    mci_reg_pkg::reg_data_t [mci_ctrl_pkg::WDT_PERIOD_DWORDS-1:0] t2_period_q;

    // Write-1-clear strobes
    assign wdt_stat_clr  = (reg_req_i.wr && reg_req_i.addr == mci_reg_pkg::ADDR_WDT_STATUS) ?
                           reg_req_i.wdata[1:0] : 2'b00;
    assign fatal_clr     = (reg_req_i.wr && reg_req_i.addr == mci_reg_pkg::ADDR_ERROR_FATAL) ?
                           reg_req_i.wdata : '0;
    assign non_fatal_clr = (reg_req_i.wr && reg_req_i.addr == mci_reg_pkg::ADDR_ERROR_NON_FATAL) ?
                           reg_req_i.wdata : '0;
    assign wdt_stat_set  = {wdt_status_i.t2_timeout_p, wdt_status_i.t1_timeout_p};
    assign t1_serviced_o = wdt_stat_clr[0];
    assign t2_serviced_o = wdt_stat_clr[1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            boot_go_q        <= 1'b0;
            mcu_rst_req_q    <= 1'b0;
            wdt_en_q         <= '0;
            wdt_restart_q    <= '0;
            wdt_stat_q       <= '0;
            err_fatal_q      <= '0;
            err_non_fatal_q  <= '0;
            fatal_mask_q     <= '0;
            non_fatal_mask_q <= '0;
            gen_out_q        <= '0;
            reg_rdata_o      <= '0;
        end else begin
            mcu_rst_req_q <= 1'b0;
            wdt_restart_q <= '0;
            // A new event wins over a clear in the same cycle
            wdt_stat_q      <= (wdt_stat_q & ~wdt_stat_clr) | wdt_stat_set;
            err_fatal_q     <= (err_fatal_q & ~fatal_clr) | agg_error_fatal_i;
            err_non_fatal_q <= (err_non_fatal_q & ~non_fatal_clr) | agg_error_non_fatal_i;
            if (reg_req_i.rd) begin
                reg_rdata_o <= rdata;
            end
            if (reg_req_i.wr) begin
                case (reg_req_i.addr)
                    mci_reg_pkg::ADDR_BOOT_GO:
                        boot_go_q <= boot_go_q | reg_req_i.wdata[0];
                    mci_reg_pkg::ADDR_RESET_REQUEST:
                        mcu_rst_req_q <= reg_req_i.wdata[0];
                    mci_reg_pkg::ADDR_WDT_T1_EN:   wdt_en_q[0] <= reg_req_i.wdata[0];
                    mci_reg_pkg::ADDR_WDT_T1_CTRL: wdt_restart_q[0] <= reg_req_i.wdata[0];
                    mci_reg_pkg::ADDR_WDT_T2_EN:   wdt_en_q[1] <= reg_req_i.wdata[0];
                    mci_reg_pkg::ADDR_WDT_T2_CTRL: wdt_restart_q[1] <= reg_req_i.wdata[0];
                    mci_reg_pkg::ADDR_ERROR_FATAL_MASK:     fatal_mask_q <= reg_req_i.wdata;
                    mci_reg_pkg::ADDR_ERROR_NON_FATAL_MASK: non_fatal_mask_q <= reg_req_i.wdata;
                    mci_reg_pkg::ADDR_GENERIC_OUT0: gen_out_q[31:0] <= reg_req_i.wdata;
                    mci_reg_pkg::ADDR_GENERIC_OUT1: gen_out_q[63:32] <= reg_req_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    // Timeout periods
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            t1_period_q <= '0;
            t2_period_q <= '0;
        end else if (reg_req_i.wr) begin
            case (reg_req_i.addr)
                mci_reg_pkg::ADDR_WDT_T1_PERIOD0: t1_period_q[0] <= reg_req_i.wdata;
                mci_reg_pkg::ADDR_WDT_T1_PERIOD1: t1_period_q[1] <= reg_req_i.wdata;
                mci_reg_pkg::ADDR_WDT_T2_PERIOD0: t2_period_q[0] <= reg_req_i.wdata;
                mci_reg_pkg::ADDR_WDT_T2_PERIOD1: t2_period_q[1] <= reg_req_i.wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        case (reg_req_i.addr)
            mci_reg_pkg::ADDR_BOOT_GO:              rdata = {31'h0, boot_go_q};
            mci_reg_pkg::ADDR_RESET_REQUEST:        rdata = {31'h0, mcu_rst_req_q};
            mci_reg_pkg::ADDR_BOOT_STATUS:          rdata = {28'h0, boot_status_i};
            mci_reg_pkg::ADDR_WDT_T1_EN:            rdata = {31'h0, wdt_en_q[0]};
            mci_reg_pkg::ADDR_WDT_T1_CTRL:          rdata = {31'h0, wdt_restart_q[0]};
            mci_reg_pkg::ADDR_WDT_T1_PERIOD0:       rdata = t1_period_q[0];
            mci_reg_pkg::ADDR_WDT_T1_PERIOD1:       rdata = t1_period_q[1];
            mci_reg_pkg::ADDR_WDT_T2_EN:            rdata = {31'h0, wdt_en_q[1]};
            mci_reg_pkg::ADDR_WDT_T2_CTRL:          rdata = {31'h0, wdt_restart_q[1]};
            mci_reg_pkg::ADDR_WDT_T2_PERIOD0:       rdata = t2_period_q[0];
            mci_reg_pkg::ADDR_WDT_T2_PERIOD1:       rdata = t2_period_q[1];
            mci_reg_pkg::ADDR_WDT_STATUS:           rdata = {30'h0, wdt_stat_q};
            mci_reg_pkg::ADDR_ERROR_FATAL:          rdata = err_fatal_q;
            mci_reg_pkg::ADDR_ERROR_NON_FATAL:      rdata = err_non_fatal_q;
            mci_reg_pkg::ADDR_ERROR_FATAL_MASK:     rdata = fatal_mask_q;
            mci_reg_pkg::ADDR_ERROR_NON_FATAL_MASK: rdata = non_fatal_mask_q;
            mci_reg_pkg::ADDR_GENERIC_IN0:          rdata = mci_generic_input_wires_i[31:0];
            mci_reg_pkg::ADDR_GENERIC_IN1:          rdata = mci_generic_input_wires_i[63:32];
            mci_reg_pkg::ADDR_GENERIC_OUT0:         rdata = gen_out_q[31:0];
            mci_reg_pkg::ADDR_GENERIC_OUT1:         rdata = gen_out_q[63:32];
            default:                                rdata = '0;
        endcase
    end

    assign boot_ctrl_o = '{boot_go: boot_go_q, mcu_rst_req: mcu_rst_req_q};

    assign wdt_cfg_o = '{
        t1_en:      wdt_en_q[0],
        t2_en:      wdt_en_q[1],
        t1_restart: wdt_restart_q[0],
        t2_restart: wdt_restart_q[1],
        t1_period:  t1_period_q,
        t2_period:  t2_period_q
    };

    // T2 expiry is always fatal
    assign all_error_fatal_o     = |(err_fatal_q & ~fatal_mask_q) | wdt_stat_q[1];
    assign all_error_non_fatal_o = |(err_non_fatal_q & ~non_fatal_mask_q);
    assign mci_intr_o            = wdt_stat_q[0];
    assign nmi_intr_o            = wdt_stat_q[1];
    assign mci_generic_output_wires_o = gen_out_q;

endmodule

//--- verilog/mci_wdt.sv
`timescale 1ns/100ps

module mci_wdt (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  mci_ctrl_pkg::wdt_cfg_t    wdt_cfg_i,
    input  logic                      t1_serviced_i,
    input  logic                      t2_serviced_i,
    output mci_ctrl_pkg::wdt_status_t wdt_status_o
);

    // Index 0 is timer 1, index 1 is timer 2
    mci_ctrl_pkg::wdt_period_t period    [2];
    mci_ctrl_pkg::wdt_period_t cnt_q     [2];
    logic                      cnt_en    [2];
    logic                      cnt_en_q  [2];
    logic                      clr       [2];
    logic                      hit       [2];
    logic                      expired_q [2];
    logic                      timeout_p_q [2];

    assign period[0] = wdt_cfg_i.t1_period;
    assign period[1] = wdt_cfg_i.t2_period;

    // In cascade mode T2 runs only while T1 is expired and unserviced
    assign cnt_en[0] = wdt_cfg_i.t1_en;
    assign cnt_en[1] = wdt_cfg_i.t2_en | (expired_q[0] & ~clr[0]);

    // Servicing T1 in cascade mode also rearms T2
    assign clr[0] = wdt_cfg_i.t1_restart | t1_serviced_i;
    assign clr[1] = wdt_cfg_i.t2_restart | t2_serviced_i | (~wdt_cfg_i.t2_en & clr[0]);

    assign hit[0] = (cnt_q[0] == period[0]);
    assign hit[1] = (cnt_q[1] == period[1]);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2; i++) begin
                cnt_q[i]       <= '0;
                cnt_en_q[i]    <= 1'b0;
                expired_q[i]   <= 1'b0;
                timeout_p_q[i] <= 1'b0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                cnt_en_q[i] <= cnt_en[i];
                // Count stops at the period until restarted or serviced
                if (clr[i]) begin
                    cnt_q[i] <= '0;
                end else if (cnt_en_q[i] && !hit[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
                // One pulse per expiry
                timeout_p_q[i] <= cnt_en_q[i] && hit[i] && !expired_q[i] && !clr[i];
                if (clr[i]) begin
                    expired_q[i] <= 1'b0;
                end else if (cnt_en_q[i] && hit[i]) begin
                    expired_q[i] <= 1'b1;
                end
            end
        end
    end

    assign wdt_status_o = '{t1_timeout_p: timeout_p_q[0], t2_timeout_p: timeout_p_q[1]};

endmodule

//--- verilog/mci_boot_seqr.sv
`timescale 1ns/100ps

module mci_boot_seqr (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  mci_ctrl_pkg::boot_ctrl_t   boot_ctrl_i,
    input  logic                       lc_done_i,
    input  logic                       fc_opt_done_i,
    input  logic                       mci_boot_seq_brkpoint_i,
    output logic                       lc_init_o,
    output logic                       fc_opt_init_o,
    output logic                       mcu_rst_b_o,
    output logic                       cptra_rst_b_o,
    output mci_ctrl_pkg::boot_status_t boot_status_o
);

    mci_ctrl_pkg::boot_state_e  state_q;
    mci_ctrl_pkg::boot_state_e  state_d;
    mci_ctrl_pkg::mcu_rst_cnt_t rst_cnt_q;
    logic                       mcu_reset_once_q;
    logic                       boot_go_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            mci_ctrl_pkg::BOOT_IDLE: begin
                state_d = mci_ctrl_pkg::BOOT_LCC;
            end
            mci_ctrl_pkg::BOOT_LCC: begin
                if (lc_done_i) begin
                    state_d = mci_ctrl_pkg::BOOT_FC;
                end
            end
            mci_ctrl_pkg::BOOT_FC: begin
                if (fc_opt_done_i) begin
                    state_d = mci_boot_seq_brkpoint_i ? mci_ctrl_pkg::BOOT_BRKPOINT
                                                      : mci_ctrl_pkg::BOOT_RUN;
                end
            end
            // Held here until firmware or debugger writes BOOT_GO
            mci_ctrl_pkg::BOOT_BRKPOINT: begin
                if (boot_ctrl_i.boot_go) begin
                    state_d = mci_ctrl_pkg::BOOT_RUN;
                end
            end
            mci_ctrl_pkg::BOOT_RUN: begin
                if (boot_ctrl_i.mcu_rst_req) begin
                    state_d = mci_ctrl_pkg::BOOT_MCU_RST;
                end
            end
            mci_ctrl_pkg::BOOT_MCU_RST: begin
                if (rst_cnt_q == '1) begin
                    state_d = mci_ctrl_pkg::BOOT_RUN;
                end
            end
            default: begin
                state_d = mci_ctrl_pkg::BOOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q          <= mci_ctrl_pkg::BOOT_IDLE;
            rst_cnt_q        <= '0;
            mcu_reset_once_q <= 1'b0;
            boot_go_q        <= 1'b0;
            lc_init_o        <= 1'b0;
            fc_opt_init_o    <= 1'b0;
            mcu_rst_b_o      <= 1'b0;
            cptra_rst_b_o    <= 1'b0;
        end else begin
            state_q       <= state_d;
            // Outputs decoded from the next state so they line up with state_q
            lc_init_o     <= (state_d == mci_ctrl_pkg::BOOT_LCC);
            fc_opt_init_o <= (state_d == mci_ctrl_pkg::BOOT_FC);
            mcu_rst_b_o   <= (state_d == mci_ctrl_pkg::BOOT_RUN);

            // Reset hold counter only runs during an MCU reset
            if (state_q == mci_ctrl_pkg::BOOT_MCU_RST) begin
                rst_cnt_q <= rst_cnt_q + 1'b1;
            end else begin
                rst_cnt_q <= '0;
            end

            if (state_d == mci_ctrl_pkg::BOOT_MCU_RST) begin
                mcu_reset_once_q <= 1'b1;
            end

            // Caliptra leaves reset once and is not touched by MCU resets
            boot_go_q <= boot_ctrl_i.boot_go;
            if (state_q == mci_ctrl_pkg::BOOT_RUN && boot_go_q) begin
                cptra_rst_b_o <= 1'b1;
            end
        end
    end

    assign boot_status_o = '{state: state_q, mcu_reset_once: mcu_reset_once_q};

endmodule

//--- verilog/mci_ctrl_pkg.sv
package mci_ctrl_pkg;

    typedef enum logic [2:0] {
        BOOT_IDLE     = 3'd0,
        BOOT_LCC      = 3'd1,
        BOOT_FC       = 3'd2,
        BOOT_BRKPOINT = 3'd3,
        BOOT_RUN      = 3'd4,
        BOOT_MCU_RST  = 3'd5
    } boot_state_e;

    // MCU reset is held for 2**MCU_RST_COUNTER_WIDTH cycles
    localparam int MCU_RST_COUNTER_WIDTH = 4;
    typedef logic [MCU_RST_COUNTER_WIDTH-1:0] mcu_rst_cnt_t;

    // Timeout period spans two register words
    localparam int WDT_PERIOD_DWORDS = 2;
    typedef logic [WDT_PERIOD_DWORDS*32-1:0] wdt_period_t;

    // Enables are levels, restarts are one-cycle pulses
    typedef struct packed {
        logic        t1_en;
        logic        t2_en;
        logic        t1_restart;
        logic        t2_restart;
        wdt_period_t t1_period;
        wdt_period_t t2_period;
    } wdt_cfg_t;

    typedef struct packed {
        logic t1_timeout_p;
        logic t2_timeout_p;
    } wdt_status_t;

    typedef struct packed {
        logic boot_go;
        logic mcu_rst_req;
    } boot_ctrl_t;

    typedef struct packed {
        boot_state_e state;
        logic        mcu_reset_once;
    } boot_status_t;

endpackage

//--- verilog/mci_reg_pkg.sv
package mci_reg_pkg;

    // Register port widths
    typedef logic [11:0] reg_addr_t;
    typedef logic [31:0] reg_data_t;

    // Subsystem-facing vectors
    typedef logic [31:0] agg_error_t;
    typedef logic [63:0] generic_wires_t;

    // Strobed request with single-cycle wr and rd and no back-pressure
    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_addr_t addr;
        reg_data_t wdata;
    } mci_reg_req_t;

    // Boot control
    localparam reg_addr_t ADDR_BOOT_GO              = 12'h000;
    localparam reg_addr_t ADDR_RESET_REQUEST        = 12'h004;
    localparam reg_addr_t ADDR_BOOT_STATUS          = 12'h008;

    // Watchdog timer 1
    localparam reg_addr_t ADDR_WDT_T1_EN            = 12'h010;
    localparam reg_addr_t ADDR_WDT_T1_CTRL          = 12'h014;
    localparam reg_addr_t ADDR_WDT_T1_PERIOD0       = 12'h018;
    localparam reg_addr_t ADDR_WDT_T1_PERIOD1       = 12'h01C;

    // Watchdog timer 2
    localparam reg_addr_t ADDR_WDT_T2_EN            = 12'h020;
    localparam reg_addr_t ADDR_WDT_T2_CTRL          = 12'h024;
    localparam reg_addr_t ADDR_WDT_T2_PERIOD0       = 12'h028;
    localparam reg_addr_t ADDR_WDT_T2_PERIOD1       = 12'h02C;
    localparam reg_addr_t ADDR_WDT_STATUS           = 12'h030;

    // Error aggregation with write-1-clear status
    localparam reg_addr_t ADDR_ERROR_FATAL          = 12'h040;
    localparam reg_addr_t ADDR_ERROR_NON_FATAL      = 12'h044;
    localparam reg_addr_t ADDR_ERROR_FATAL_MASK     = 12'h048;
    localparam reg_addr_t ADDR_ERROR_NON_FATAL_MASK = 12'h04C;

    // Generic wires with the low word at the lower offset
    localparam reg_addr_t ADDR_GENERIC_IN0          = 12'h080;
    localparam reg_addr_t ADDR_GENERIC_IN1          = 12'h084;
    localparam reg_addr_t ADDR_GENERIC_OUT0         = 12'h088;
    localparam reg_addr_t ADDR_GENERIC_OUT1         = 12'h08C;

endpackage
